// File: core_if_fetch_unit.f
rtl/core_if_pkg.sv
rtl/core_if_generate_access_bus_addr.sv
rtl/core_if_wait_fifo.sv
rtl/core_if_shift_buff.sv
rtl/core_if_bus_fsm.sv
rtl/core_if_discard_counter.sv
rtl/core_if_fetch_unit.sv
testbench/core_if_properties.sv
testbench/core_if_checker.sv
testbench/tb_core_if_fetch_unit.sv

// File: Bender.yml
package:
  name: core_if

sources:
  - rtl/core_if_pkg.sv
  - rtl/core_if_generate_access_bus_addr.sv
  - rtl/core_if_wait_fifo.sv
  - rtl/core_if_shift_buff.sv
  - rtl/core_if_bus_fsm.sv
  - rtl/core_if_discard_counter.sv
  - rtl/core_if_fetch_unit.sv
  - target: test
    files:
      - testbench/core_if_properties.sv
      - testbench/core_if_checker.sv
      - testbench/tb_core_if_fetch_unit.sv

// File: testbench/tb_core_if_fetch_unit.sv
// Testbench for the instruction fetch front end
// Drives pc, next_pc and flush like a core that waits for inst_valid
// Models AXI4-Lite instruction memory with random AR and R delays
// core_if_checker does the comparing, assertions are bound into the DUT
`timescale 1ns/10ps

module tb_core_if_fetch_unit;

  localparam int WAIT_FIFO_MAX_NUM  = 2;
  localparam int SHIFT_BUFF_MAX_NUM = 2;
  localparam int PREFETCHED_NUM     = 2;
  // Instructions consumed over all five tests
  localparam int TOTAL_INST  = 36;
  localparam int CYCLE_LIMIT = 40 * TOTAL_INST + 200;

  logic               clk, rst_n, flush, inst_valid, test_end;
  logic               arvalid, arready, rvalid, rready;
  logic [1:0]         rresp;
  core_if_pkg::addr_t pc, next_pc, araddr;
  core_if_pkg::inst_t inst, rdata;
  int                 test_num, checks, errors, total_fails, cycle_count, seed_val;
  // Memory side bookkeeping
  core_if_pkg::addr_t rd_q [$];
  logic               ar_armed, r_armed, r_hs;
  int                 ar_wait, r_wait;

  core_if_fetch_unit #(
    .WAIT_FIFO_MAX_NUM (WAIT_FIFO_MAX_NUM),
    .SHIFT_BUFF_MAX_NUM(SHIFT_BUFF_MAX_NUM),
    .PREFETCHED_NUM    (PREFETCHED_NUM)
  ) UUT (
    .clk(clk), .rst_n(rst_n), .pc(pc), .next_pc(next_pc), .flush(flush),
    .inst(inst), .inst_valid(inst_valid), .araddr(araddr), .arvalid(arvalid),
    .arready(arready), .rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready)
  );

  core_if_checker #(
    .WAIT_FIFO_MAX_NUM(WAIT_FIFO_MAX_NUM)
  ) u_checker (
    .clk(clk), .rst_n(rst_n), .pc(pc), .flush(flush), .inst(inst), .inst_valid(inst_valid),
    .araddr(araddr), .arvalid(arvalid), .arready(arready), .rvalid(rvalid), .rready(rready),
    .test_num(test_num), .test_end(test_end), .checks(checks), .errors(errors)
  );

  bind core_if_fetch_unit core_if_properties #(
    .WAIT_FIFO_MAX_NUM(WAIT_FIFO_MAX_NUM)
  ) u_props (
    .clk(clk), .rst_n(rst_n), .arvalid(arvalid), .arready(arready), .araddr(araddr),
    .rready(rready), .inst_valid(inst_valid), .push(push), .fifo_full(fifo_full),
    .fifo_count(fifo_count)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  ////////////////////
  // Memory model
  ////////////////////

  function automatic core_if_pkg::inst_t mem_data(input core_if_pkg::addr_t addr);
    return {addr[31:2], 2'b00} ^ 32'h5A5A_0000;
  endfunction

  // Handshakes seen at the clock edge
  always @(posedge clk) begin
    if (!rst_n) begin
      rd_q.delete();
      r_hs = 1'b0;
    end else begin
      r_hs = rvalid && rready;
      if (r_hs) begin
        rd_q.pop_front();
      end
      if (arvalid && arready) begin
        rd_q.push_back(araddr);
      end
    end
  end

  // arready and rvalid each come 0 to 3 cycles late
  always @(negedge clk) begin
    if (!rst_n) begin
      arready  = 1'b0;
      rvalid   = 1'b0;
      ar_armed = 1'b0;
      r_armed  = 1'b0;
    end else begin
      if (arready) begin
        arready = 1'b0;
      end else if (arvalid) begin
        if (!ar_armed) begin
          ar_armed = 1'b1;
          ar_wait  = $urandom % 4;
        end
        if (ar_wait == 0) begin
          arready  = 1'b1;
          ar_armed = 1'b0;
        end else begin
          ar_wait--;
        end
      end
      if (r_hs) begin
        rvalid = 1'b0;
      end
      // Beat held until rready takes it
      if (!rvalid && rd_q.size() > 0) begin
        if (!r_armed) begin
          r_armed = 1'b1;
          r_wait  = $urandom % 4;
        end
        if (r_wait == 0) begin
          rvalid  = 1'b1;
          rdata   = mem_data(rd_q[0]);
          r_armed = 1'b0;
        end else begin
          r_wait--;
        end
      end
    end
  end

  ////////////////////
  // Core model
  ////////////////////

  // Straight line, or a loop of wrap words back to base
  function automatic core_if_pkg::addr_t step_pc(input core_if_pkg::addr_t cur,
                                                 input core_if_pkg::addr_t base,
                                                 input int wrap);
    if (wrap > 0 && cur == base + core_if_pkg::addr_t'(4 * (wrap - 1))) begin
      return base;
    end
    return cur + 32'd4;
  endfunction

  // Called on a falling edge, flush lasts one cycle
  task automatic redirect(input core_if_pkg::addr_t new_pc, input core_if_pkg::addr_t new_next);
    flush   = 1'b1;
    pc      = new_pc;
    next_pc = new_next;
    @(negedge clk);
    flush = 1'b0;
  endtask

  // Valid at a falling edge means consumed at the next rising edge
  task automatic run_stream(input core_if_pkg::addr_t base, input int count,
                            input int hold, input int wrap);
    int done;
    done = 0;
    while (done < count) begin
      @(negedge clk);
      if (inst_valid) begin
        done++;
        repeat (hold + 1) @(negedge clk);
        pc      = next_pc;
        next_pc = step_pc(next_pc, base, wrap);
      end
    end
  endtask

  task automatic end_test();
    test_end = 1'b1;
    @(negedge clk);
    test_end = 1'b0;
  endtask

  ////////////////////
  // Test sequence
  ////////////////////

  initial begin
    seed_val = $urandom(92);
    rst_n    = 1'b0;
    flush    = 1'b0;
    pc       = 32'h0000_1000;
    next_pc  = 32'h0000_1004;
    arready  = 1'b0;
    rvalid   = 1'b0;
    rdata    = '0;
    rresp    = 2'b00;
    test_num = 0;
    test_end = 1'b0;
    repeat (4) @(negedge clk);
    rst_n = 1'b1;
    test_num = 1;
    redirect(32'h0000_1000, 32'h0000_1004);
    run_stream(32'h0000_1000, 8, 0, 0);
    end_test();
    test_num = 2;
    redirect(32'h0000_2002, 32'h0000_2006);
    run_stream(32'h0000_2002, 8, 0, 0);
    end_test();
    // Second flush lands while prefetches are in flight
    test_num = 3;
    redirect(32'h0000_3000, 32'h0000_3004);
    run_stream(32'h0000_3000, 3, 0, 0);
    redirect(32'h0000_3800, 32'h0000_3804);
    run_stream(32'h0000_3800, 5, 0, 0);
    end_test();
    // Three word loop revisits the same words
    test_num = 4;
    redirect(32'h0000_4000, 32'h0000_4004);
    run_stream(32'h0000_4000, 8, 1, 3);
    end_test();
    // Core stalls long enough for the FIFO and buffer to fill
    test_num = 5;
    redirect(32'h0000_5000, 32'h0000_5004);
    run_stream(32'h0000_5000, 4, 20, 0);
    end_test();
    total_fails = errors + UUT.u_props.assert_fails;
    $display("tests 5, checks %0d, errors %0d, assertion failures %0d",
             checks, errors, UUT.u_props.assert_fails);
    if (total_fails == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

  // Run limit
  initial begin
    cycle_count = 0;
    while (cycle_count < CYCLE_LIMIT) begin
      @(posedge clk);
      cycle_count++;
    end
    $display("ERROR: run did not finish within %0d cycles", CYCLE_LIMIT);
    $display("SIMULATION FAILED");
    $finish;
  end

endmodule

// File: testbench/core_if_checker.sv
// Scoreboard for the fetch unit testbench
// Compares inst with the memory pattern whenever inst_valid is high
// Tracks issued reads to catch duplicate ARs and too many reads in flight
// Prints one line per test when test_end pulses
`timescale 1ns/10ps

module core_if_checker #(
  parameter int WAIT_FIFO_MAX_NUM = 2
) (
  input  logic               clk,
  input  logic               rst_n,
  input  core_if_pkg::addr_t pc,
  input  logic               flush,
  input  core_if_pkg::inst_t inst,
  input  logic               inst_valid,
  input  core_if_pkg::addr_t araddr,
  input  logic               arvalid,
  input  logic               arready,
  input  logic               rvalid,
  input  logic               rready,
  input  int                 test_num,
  input  logic               test_end,
  output int                 checks,
  output int                 errors
);

  // Reads issued and not yet answered, oldest first
  core_if_pkg::addr_t out_addr [$];
  // Set for reads issued before a flush
  logic               out_stale [$];
  int                 test_checks;
  int                 test_errors;
  int                 test_dropped;
  logic               ar_open;
  core_if_pkg::addr_t ar_open_addr;

  ////////////////////
  // Reference model
  ////////////////////

  // Memory pattern with each word holding its own address scrambled
  function automatic core_if_pkg::inst_t mem_word(input core_if_pkg::addr_t addr);
    return {addr[31:2], 2'b00} ^ 32'h5A5A_0000;
  endfunction

  // Halfword-aligned pc joins top half of its word with bottom half of the next
  function automatic core_if_pkg::inst_t expected_inst(input core_if_pkg::addr_t at);
    core_if_pkg::inst_t lo;
    core_if_pkg::inst_t hi;
    lo = mem_word(at);
    hi = mem_word(at + 32'd4);
    return at[1] ? {hi[15:0], lo[31:16]} : lo;
  endfunction

  function automatic string test_name(input int num);
    case (num)
      1:       return "seq_fetch";
      2:       return "unaligned";
      3:       return "redirect";
      4:       return "no_duplicate";
      5:       return "backpressure";
      default: return "startup";
    endcase
  endfunction

  // Reads that the DUT still expects to keep
  function automatic int live_reads();
    int n;
    n = 0;
    foreach (out_stale[i]) begin
      if (!out_stale[i]) begin
        n++;
      end
    end
    return n;
  endfunction

  task automatic note_failure(input string what);
    $display("ERROR %s: %s at %0t", test_name(test_num), what, $time);
    errors++;
    test_errors++;
  endtask

  ////////////////////
  // Comparing
  ////////////////////

  always @(posedge clk) begin
    core_if_pkg::inst_t exp_inst;
    logic               done_stale;
    if (!rst_n) begin
      out_addr.delete();
      out_stale.delete();
      ar_open = 1'b0;
    end else begin
      if (inst_valid) begin
        exp_inst = expected_inst(pc);
        checks++;
        test_checks++;
        if (inst !== exp_inst) begin
          $display("MISMATCH %s: pc %h expected %h actual %h",
                   test_name(test_num), pc, exp_inst, inst);
          errors++;
          test_errors++;
        end
      end
      // Open AR must still be there with the same address
      if (ar_open && (!arvalid || araddr !== ar_open_addr)) begin
        note_failure("arvalid dropped or araddr moved before arready");
      end
      ar_open      = arvalid && !arready;
      ar_open_addr = araddr;
      // Memory answers in order so each beat retires the oldest read
      if (rvalid && rready) begin
        out_addr.delete(0);
        done_stale = out_stale.pop_front();
        if (done_stale) begin
          test_dropped++;
        end
      end
      if (arvalid && arready) begin
        foreach (out_addr[i]) begin
          if (!out_stale[i] && out_addr[i] == araddr) begin
            note_failure($sformatf("duplicate AR to %h while still outstanding", araddr));
          end
        end
        out_addr.push_back(araddr);
        out_stale.push_back(1'b0);
      end
      // Everything handshaked up to the flush is dropped by the DUT
      if (flush) begin
        foreach (out_stale[i]) begin
          out_stale[i] = 1'b1;
        end
      end
      if (live_reads() > WAIT_FIFO_MAX_NUM) begin
        note_failure("more reads outstanding than the wait FIFO holds");
      end
      if (test_end) begin
        $display("test %s done: %0d checks, %0d errors, %0d stale beats dropped",
                 test_name(test_num), test_checks, test_errors, test_dropped);
        test_checks  = 0;
        test_errors  = 0;
        test_dropped = 0;
      end
    end
  end

endmodule

// File: testbench/core_if_properties.sv
// Bound assertions for the fetch unit top level
// Watches the AR handshake, reset state and wait FIFO occupancy
// Failures raise $error and bump assert_fails for the end of run summary
`timescale 1ns/10ps

module core_if_properties #(
  parameter int WAIT_FIFO_MAX_NUM = 2
) (
  input logic              clk,
  input logic              rst_n,
  input logic              arvalid,
  input logic              arready,
  input core_if_pkg::addr_t araddr,
  input logic              rready,
  input logic              inst_valid,
  input logic              push,
  input logic              fifo_full,
  input core_if_pkg::cnt_t fifo_count
);

  int assert_fails = 0;

  // AR stays up with the same address until arready
  ar_hold: assert property (@(posedge clk) disable iff (!rst_n)
    arvalid && !arready |=> arvalid && $stable(araddr))
    else begin
      $error("AR request dropped or address changed before arready");
      assert_fails++;
    end

  // Reset leaves the bus idle and rready open
  reset_state: assert property (@(posedge clk)
    !rst_n |=> !arvalid && !inst_valid && rready)
    else begin
      $error("outputs not in reset state after reset");
      assert_fails++;
    end

  // Handshake never pushes into a full wait FIFO
  no_overrun: assert property (@(posedge clk) disable iff (!rst_n)
    push |-> !fifo_full)
    else begin
      $error("wait FIFO pushed while full");
      assert_fails++;
    end

  // Reads owed never exceed the FIFO depth
  count_bound: assert property (@(posedge clk) disable iff (!rst_n)
    fifo_count <= core_if_pkg::cnt_t'(WAIT_FIFO_MAX_NUM))
    else begin
      $error("wait FIFO count above its depth");
      assert_fails++;
    end

endmodule

// File: rtl/core_if_fetch_unit.sv
// Instruction fetch front end, top level
// Turns pc and next_pc into AXI4-Lite word reads and returns the instruction at pc
// The core holds pc until inst_valid, flush redirects to a new pc
`timescale 1ns/10ps

module core_if_fetch_unit #(
  parameter int WAIT_FIFO_MAX_NUM  = 2,
  parameter int SHIFT_BUFF_MAX_NUM = 2,
  parameter int PREFETCHED_NUM     = 2
) (
  input  logic               clk,
  input  logic               rst_n,
  // Core side
  input  core_if_pkg::addr_t pc,
  input  core_if_pkg::addr_t next_pc,
  input  logic               flush,
  output core_if_pkg::inst_t inst,
  output logic               inst_valid,
  // AXI4-Lite read channels, rresp is not checked
  output core_if_pkg::addr_t araddr,
  output logic               arvalid,
  input  logic               arready,
  input  core_if_pkg::inst_t rdata,
  input  logic [1:0]         rresp,
  input  logic               rvalid,
  output logic               rready
);

  core_if_pkg::sent_addr_t all_sent_addr [WAIT_FIFO_MAX_NUM+SHIFT_BUFF_MAX_NUM-1:0];
  core_if_pkg::sent_addr_t fifo_sent_addr [WAIT_FIFO_MAX_NUM-1:0];
  logic [1:0]              pc_read_data_request;
  core_if_pkg::addr_t      read_addr, head_addr;
  core_if_pkg::cnt_t       fifo_count;
  logic                    read, fifo_full, buff_space, discard_pending;
  logic                    push, pop, discard_dec, buff_wr, ar_done;

  core_if_generate_access_bus_addr #(
    .WAIT_FIFO_MAX_NUM (WAIT_FIFO_MAX_NUM),
    .SHIFT_BUFF_MAX_NUM(SHIFT_BUFF_MAX_NUM),
    .PREFETCHED_NUM    (PREFETCHED_NUM)
  ) u_addr_gen (
    .next_pc(next_pc), .pc(pc), .pc_read_data_request(pc_read_data_request),
    .all_sent_addr(all_sent_addr), .read_addr(read_addr), .read(read)
  );

  core_if_wait_fifo #(
    .WAIT_FIFO_MAX_NUM(WAIT_FIFO_MAX_NUM)
  ) u_wait_fifo (
    .clk(clk), .rst_n(rst_n), .flush(flush), .push(push), .push_addr(araddr), .pop(pop),
    .head_addr(head_addr), .full(fifo_full), .count(fifo_count), .sent_addr(fifo_sent_addr)
  );

  core_if_shift_buff #(
    .SHIFT_BUFF_MAX_NUM(SHIFT_BUFF_MAX_NUM),
    .WAIT_FIFO_MAX_NUM (WAIT_FIFO_MAX_NUM),
    .PREFETCHED_NUM    (PREFETCHED_NUM)
  ) u_shift_buff (
    .clk(clk), .rst_n(rst_n), .flush(flush), .pc(pc), .next_pc(next_pc),
    .wr_en(buff_wr), .wr_addr(head_addr), .wr_data(rdata), .fifo_sent_addr(fifo_sent_addr),
    .all_sent_addr(all_sent_addr), .pc_read_data_request(pc_read_data_request),
    .space(buff_space), .inst(inst), .inst_valid(inst_valid)
  );

  core_if_bus_fsm u_bus_fsm (
    .clk(clk), .rst_n(rst_n), .read(read), .read_addr(read_addr), .fifo_full(fifo_full),
    .discard_pending(discard_pending), .buff_space(buff_space),
    .araddr(araddr), .arvalid(arvalid), .arready(arready), .rvalid(rvalid), .rready(rready),
    .push(push), .pop(pop), .discard_dec(discard_dec), .buff_wr(buff_wr), .ar_done(ar_done)
  );

  core_if_discard_counter u_discard_cnt (
    .clk(clk), .rst_n(rst_n), .flush(flush), .fifo_count(fifo_count), .ar_done(ar_done),
    .discard_dec(discard_dec), .discard_pending(discard_pending)
  );

endmodule

// File: rtl/core_if_discard_counter.sv
// Count of R beats still owed to reads issued before a flush
// The bus FSM drops that many beats before writing the buffer again
`timescale 1ns/10ps

module core_if_discard_counter (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              flush,
  input  core_if_pkg::cnt_t fifo_count,
  input  logic              ar_done,
  input  logic              discard_dec,
  output logic              discard_pending
);

  core_if_pkg::cnt_t remain;
  core_if_pkg::cnt_t remain_dec;

  // Drops still owed after this cycle's beat
  assign remain_dec = remain - core_if_pkg::cnt_t'(discard_dec);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      remain <= '0;
    end else if (flush) begin
      // Older drops plus reads left in the FIFO plus an AR finishing now
      remain <= remain_dec + fifo_count + core_if_pkg::cnt_t'(ar_done);
    end else begin
      remain <= remain_dec;
    end
  end

  assign discard_pending = (remain != '0);

endmodule

// File: rtl/core_if_bus_fsm.sv
// AXI4-Lite read handshakes for the fetch unit
// Launches one AR at a time and routes each R beat to the buffer or the drop count
`timescale 1ns/10ps

module core_if_bus_fsm (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               read,
  input  core_if_pkg::addr_t read_addr,
  input  logic               fifo_full,
  input  logic               discard_pending,
  input  logic               buff_space,
  output core_if_pkg::addr_t araddr,
  output logic               arvalid,
  input  logic               arready,
  input  logic               rvalid,
  output logic               rready,
  output logic               push,
  output logic               pop,
  output logic               discard_dec,
  output logic               buff_wr,
  output logic               ar_done
);

  typedef enum logic {
    IDLE,
    ADDR
  } state_t;

  state_t state;
  logic   ar_accept;
  logic   r_beat;

  ////////////////////
  // AR channel
  ////////////////////

  // New read only with room left in the wait FIFO
  assign ar_accept = (state == IDLE) && read && !fifo_full;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state <= IDLE;
    end else begin
      case (state)
        IDLE: if (ar_accept) state <= ADDR;
        ADDR: if (arready) state <= IDLE;
        default: state <= IDLE;
      endcase
    end
  end

  // Address held stable until arready
  always_ff @(posedge clk) begin
    if (ar_accept) begin
      araddr <= read_addr;
    end
  end

  assign arvalid = (state == ADDR);
  assign ar_done = arvalid && arready;
  assign push    = ar_done;

  ////////////////////
  // R channel
  ////////////////////

  // Stale beats are always taken, fresh ones need a free entry
  assign rready = discard_pending || buff_space;
  assign r_beat = rvalid && rready;

  // Stale beats never reach the wait FIFO, it was emptied at the flush
  assign discard_dec = r_beat && discard_pending;
  assign pop         = r_beat && !discard_pending;
  assign buff_wr     = pop;

endmodule

// File: rtl/core_if_shift_buff.sv
// Buffer of returned words for the fetch unit
// Keeps only words near pc and next_pc and builds the instruction at pc
// Also raises demand requests for pc words that are neither held nor in flight
`timescale 1ns/10ps

module core_if_shift_buff #(
  parameter int SHIFT_BUFF_MAX_NUM = 2,
  parameter int WAIT_FIFO_MAX_NUM  = 2,
  parameter int PREFETCHED_NUM     = 2
) (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    flush,
  input  core_if_pkg::addr_t      pc,
  input  core_if_pkg::addr_t      next_pc,
  input  logic                    wr_en,
  input  core_if_pkg::addr_t      wr_addr,
  input  core_if_pkg::inst_t      wr_data,
  input  core_if_pkg::sent_addr_t fifo_sent_addr [WAIT_FIFO_MAX_NUM-1:0],
  output core_if_pkg::sent_addr_t all_sent_addr [WAIT_FIFO_MAX_NUM+SHIFT_BUFF_MAX_NUM-1:0],
  output logic [1:0]              pc_read_data_request,
  output logic                    space,
  output core_if_pkg::inst_t      inst,
  output logic                    inst_valid
);

  localparam int TRACK_NUM = WAIT_FIFO_MAX_NUM + SHIFT_BUFF_MAX_NUM;

  logic [29:0]                   buf_word [SHIFT_BUFF_MAX_NUM-1:0];
  core_if_pkg::inst_t            buf_data [SHIFT_BUFF_MAX_NUM-1:0];
  logic [SHIFT_BUFF_MAX_NUM-1:0] buf_valid;
  logic [SHIFT_BUFF_MAX_NUM-1:0] is_demand, in_window, keep_base, keep, free, wr_sel;
  logic [29:0]                   lo_word, hi_word;
  logic                          lo_held, hi_held, lo_sent, hi_sent, starved;
  core_if_pkg::inst_t            lo_data, hi_data;

  // Word at pc and the word after it
  assign lo_word = pc[31:2];
  assign hi_word = pc[31:2] + 30'd1;

  ////////////////////
  // Retention
  ////////////////////

  always_comb begin
    for (int i = 0; i < SHIFT_BUFF_MAX_NUM; i++) begin
      is_demand[i] = (buf_word[i] == lo_word) || (buf_word[i] == hi_word);
      in_window[i] = is_demand[i];
      for (int p = 0; p < PREFETCHED_NUM; p++) begin
        if (buf_word[i] == next_pc[31:2] + 30'(p)) begin
          in_window[i] = 1'b1;
        end
      end
    end
  end

  assign keep_base = buf_valid & in_window;

  // Full of prefetch words while a pc word is missing
  // then give up the prefetch entries so the demand beat can land
  assign starved = (&keep_base) && (!lo_held || (pc[1] && !hi_held));
  assign keep    = starved ? (keep_base & is_demand) : keep_base;

  // Flush drops everything, a beat in that cycle still lands in entry 0
  assign free  = flush ? '1 : ~keep;
  assign space = |(~keep);

  // First free entry
  always_comb begin
    logic taken;
    taken  = 1'b0;
    wr_sel = '0;
    for (int i = 0; i < SHIFT_BUFF_MAX_NUM; i++) begin
      if (free[i] && !taken) begin
        wr_sel[i] = 1'b1;
        taken     = 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      buf_valid <= '0;
    end else begin
      buf_valid <= (flush ? '0 : keep) | (wr_en ? wr_sel : '0);
    end
  end

  // Word payload
  always_ff @(posedge clk) begin
    for (int i = 0; i < SHIFT_BUFF_MAX_NUM; i++) begin
      if (wr_en && wr_sel[i]) begin
        buf_word[i] <= wr_addr[31:2];
        buf_data[i] <= wr_data;
      end
    end
  end

  ////////////////////
  // Lookup and requests
  ////////////////////

  always_comb begin
    lo_held = 1'b0;
    hi_held = 1'b0;
    lo_data = '0;
    hi_data = '0;
    for (int i = 0; i < SHIFT_BUFF_MAX_NUM; i++) begin
      if (buf_valid[i] && buf_word[i] == lo_word) begin
        lo_held = 1'b1;
        lo_data = buf_data[i];
      end
      if (buf_valid[i] && buf_word[i] == hi_word) begin
        hi_held = 1'b1;
        hi_data = buf_data[i];
      end
    end
  end

  // FIFO slots first, then the buffer's own entries
  for (genvar i = 0; i < WAIT_FIFO_MAX_NUM; i++) begin : g_fifo_sent
    assign all_sent_addr[i] = fifo_sent_addr[i];
  end
  for (genvar i = 0; i < SHIFT_BUFF_MAX_NUM; i++) begin : g_buf_sent
    assign all_sent_addr[WAIT_FIFO_MAX_NUM+i] = core_if_pkg::make_sent(buf_valid[i], buf_word[i]);
  end

  always_comb begin
    lo_sent = 1'b0;
    hi_sent = 1'b0;
    for (int j = 0; j < TRACK_NUM; j++) begin
      lo_sent = lo_sent || core_if_pkg::sent_hit(all_sent_addr[j], lo_word);
      hi_sent = hi_sent || core_if_pkg::sent_hit(all_sent_addr[j], hi_word);
    end
  end

  // Upper word is only wanted for a halfword-aligned pc
  assign pc_read_data_request = {pc[1] && !hi_sent, !lo_sent};

  ////////////////////
  // Instruction
  ////////////////////

  // Split instruction takes its low half from the top of the pc word
  assign inst       = pc[1] ? {hi_data[15:0], lo_data[31:16]} : lo_data;
  assign inst_valid = lo_held && (!pc[1] || hi_held) && !flush;

endmodule

// File: rtl/core_if_wait_fifo.sv
// Circular FIFO of read addresses whose R beats have not come back yet
// Pushed on the AR handshake, popped on each R beat that is kept
// Each slot is also exported in the tracked format for duplicate checks
`timescale 1ns/10ps

module core_if_wait_fifo #(
  parameter int WAIT_FIFO_MAX_NUM = 2
) (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    flush,
  input  logic                    push,
  input  core_if_pkg::addr_t      push_addr,
  input  logic                    pop,
  output core_if_pkg::addr_t      head_addr,
  output logic                    full,
  output core_if_pkg::cnt_t       count,
  output core_if_pkg::sent_addr_t sent_addr [WAIT_FIFO_MAX_NUM-1:0]
);

  localparam int PTR_W = (WAIT_FIFO_MAX_NUM > 1) ? $clog2(WAIT_FIFO_MAX_NUM) : 1;
  localparam logic [PTR_W-1:0] LAST_SLOT = PTR_W'(WAIT_FIFO_MAX_NUM - 1);

  logic [29:0]                  slot_word [WAIT_FIFO_MAX_NUM-1:0];
  logic [WAIT_FIFO_MAX_NUM-1:0] slot_valid;
  logic [PTR_W-1:0]             wr_ptr;
  logic [PTR_W-1:0]             rd_ptr;
  core_if_pkg::cnt_t            occ;

  // Pointer step with wrap for depths that are not a power of two
  function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
    return (ptr == LAST_SLOT) ? '0 : ptr + 1'b1;
  endfunction

  ////////////////////
  // Pointers and occupancy
  ////////////////////

  always_ff @(posedge clk) begin
    if (!rst_n || flush) begin
      wr_ptr     <= '0;
      rd_ptr     <= '0;
      occ        <= '0;
      slot_valid <= '0;
    end else begin
      if (push) begin
        wr_ptr             <= next_ptr(wr_ptr);
        slot_valid[wr_ptr] <= 1'b1;
      end
      if (pop) begin
        rd_ptr             <= next_ptr(rd_ptr);
        slot_valid[rd_ptr] <= 1'b0;
      end
      occ <= occ + core_if_pkg::cnt_t'(push) - core_if_pkg::cnt_t'(pop);
    end
  end

  // Address storage
  always_ff @(posedge clk) begin
    if (push) begin
      slot_word[wr_ptr] <= push_addr[31:2];
    end
  end

  ////////////////////
  // Outputs
  ////////////////////

  assign head_addr = {slot_word[rd_ptr], 2'b00};
  assign full      = (occ == core_if_pkg::cnt_t'(WAIT_FIFO_MAX_NUM));

  // Reads still owed after this cycle's beat
  // so a flush in the same cycle counts only the ones left
  assign count = occ - core_if_pkg::cnt_t'(pop);

  for (genvar i = 0; i < WAIT_FIFO_MAX_NUM; i++) begin : g_sent
    assign sent_addr[i] = core_if_pkg::make_sent(slot_valid[i], slot_word[i]);
  end

endmodule

// File: rtl/core_if_generate_access_bus_addr.sv
// Read address choice for the fetch unit
// Demand words for pc and pc+4 go first, then the prefetch words from next_pc
// Purely combinational, the bus FSM samples read and read_addr when idle
`timescale 1ns/10ps

module core_if_generate_access_bus_addr #(
  parameter int WAIT_FIFO_MAX_NUM  = 2,
  parameter int SHIFT_BUFF_MAX_NUM = 2,
  parameter int PREFETCHED_NUM     = 2
) (
  input  core_if_pkg::addr_t      next_pc,
  input  core_if_pkg::addr_t      pc,
  input  logic [1:0]              pc_read_data_request,
  input  core_if_pkg::sent_addr_t all_sent_addr [WAIT_FIFO_MAX_NUM+SHIFT_BUFF_MAX_NUM-1:0],
  output core_if_pkg::addr_t      read_addr,
  output logic                    read
);

  // Every word that is either in flight or held in the buffer
  localparam int TRACK_NUM = WAIT_FIFO_MAX_NUM + SHIFT_BUFF_MAX_NUM;

  logic [29:0]               pf_word [PREFETCHED_NUM-1:0];
  logic [PREFETCHED_NUM-1:0] pf_sent;
  logic [29:0]               pick_word;

  ////////////////////
  // Prefetch window
  ////////////////////

  // Word addresses next_pc, next_pc+4 and onward
  always_comb begin
    for (int i = 0; i < PREFETCHED_NUM; i++) begin
      pf_word[i] = next_pc[31:2] + 30'(i);
    end
  end

  // Mark prefetch words already held or already requested
  always_comb begin
    for (int i = 0; i < PREFETCHED_NUM; i++) begin
      pf_sent[i] = 1'b0;
      for (int j = 0; j < TRACK_NUM; j++) begin
        pf_sent[i] = pf_sent[i] || core_if_pkg::sent_hit(all_sent_addr[j], pf_word[i]);
      end
    end
  end

  ////////////////////
  // Selection
  ////////////////////

  always_comb begin
    logic found;
    found     = 1'b0;
    pick_word = pc[31:2];
    read      = 1'b0;
    if (pc_read_data_request[0]) begin
      // Word holding the low half of the instruction
      pick_word = pc[31:2];
      read      = 1'b1;
    end else if (pc_read_data_request[1]) begin
      // Upper half of a split instruction lives in the next word
      pick_word = pc[31:2] + 30'd1;
      read      = 1'b1;
    end else begin
      // Lowest prefetch word not yet sent
      for (int i = 0; i < PREFETCHED_NUM; i++) begin
        if (!found && !pf_sent[i]) begin
          found     = 1'b1;
          pick_word = pf_word[i];
        end
      end
      read = found;
    end
  end

  // Reads are always whole words
  assign read_addr = {pick_word, 2'b00};

endmodule

// File: rtl/core_if_pkg.sv
// Shared types and helpers for the instruction fetch front end
// Every RTL file refers to these by scoped names
// Compile this package before any module of the fetch unit
package core_if_pkg;

  // Byte address on the core side and on the AXI4-Lite read port
  typedef logic [31:0] addr_t;

  // Instruction or memory word
  typedef logic [31:0] inst_t;

  // Tracked word as valid flag, spare bit and word address
  typedef logic [31:0] sent_addr_t;

  // Occupancy or discard count, good for depths up to 15
  typedef logic [3:0] cnt_t;

  // Field positions inside sent_addr_t
  localparam int SENT_VALID_BIT = 31;
  localparam int SENT_ADDR_MSB  = 29;

  // Pack a word address into the tracked format
  function automatic sent_addr_t make_sent(input logic valid,
                                           input logic [SENT_ADDR_MSB:0] word);
    sent_addr_t packed_word;
    packed_word = '0;
    packed_word[SENT_VALID_BIT] = valid;
    packed_word[SENT_ADDR_MSB:0] = word;
    return packed_word;
  endfunction

  // Valid tracked entry holding this word
  function automatic logic sent_hit(input sent_addr_t entry, input logic [SENT_ADDR_MSB:0] word);
    return entry[SENT_VALID_BIT] && (entry[SENT_ADDR_MSB:0] == word);
  endfunction

endpackage
